// ==== include/rename_config.svh ====
/*
 * Sizing of the integer rename stage. Included by the packages and by every
 * module that needs a width or a count.
 */

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Instructions renamed per cycle
`define RENAME_WIDTH 2

// Register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

// Number of stored recovery points
`define CHECKPOINTS 4

// Index widths derived from the counts above
`define AREG_BITS $clog2(`ARCH_REGS)
`define PREG_BITS $clog2(`PHYS_REGS)
`define CKPT_BITS $clog2(`CHECKPOINTS)
`define SLOT_BITS $clog2(`RENAME_WIDTH)

`endif

// ==== hw/rename_types_pkg.sv ====
/*
 * Index types of the rename stage. Every register, checkpoint and queue
 * pointer in the design is declared with one of these.
 */

`default_nettype none

`include "rename_config.svh"

package rename_types_pkg;

  // Architectural register number
  typedef logic [`AREG_BITS-1:0] areg_t;

  // Physical register number
  typedef logic [`PREG_BITS-1:0] preg_t;

  // Checkpoint slot
  typedef logic [`CKPT_BITS-1:0] ckpt_idx_t;

  // Position of an instruction within its group
  typedef logic [`SLOT_BITS-1:0] slot_idx_t;

  // Free-list pointer, extra MSB tells full from empty
  typedef logic [`PREG_BITS:0] fl_ptr_t;

endpackage

`default_nettype wire

// ==== hw/rename_ops_pkg.sv ====
/*
 * Bundles exchanged by the rename stage: per-slot requests and responses,
 * register releases from commit, and the recovery snapshot.
 */

`default_nettype none

`include "rename_config.svh"

package rename_ops_pkg;

  // One instruction of a rename group
  typedef struct packed {
    logic                  valid;
    rename_types_pkg::areg_t rs1;
    rename_types_pkg::areg_t rs2;
    rename_types_pkg::areg_t rd;
  } rename_req_t;

  // Renamed operands, prev_prd is freed when the instruction commits
  typedef struct packed {
    rename_types_pkg::preg_t prs1;
    rename_types_pkg::preg_t prs2;
    rename_types_pkg::preg_t prd;
    rename_types_pkg::preg_t prev_prd;
  } rename_rsp_t;

  // Register handed back by commit
  typedef struct packed {
    logic                  valid;
    rename_types_pkg::preg_t preg;
  } release_t;

  // Full map plus the free-list head at the same point
  typedef struct packed {
    rename_types_pkg::preg_t [`ARCH_REGS-1:0] map;
    rename_types_pkg::fl_ptr_t               fl_head;
  } snapshot_t;

endpackage

`default_nettype wire

// ==== hw/free_list.sv ====
/*
 * Circular queue of free physical registers. Up to RENAME_WIDTH registers
 * leave at the head per cycle, released ones join at the tail, and the head
 * can be rolled back to a checkpointed value.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module free_list (
  input  logic                                           clock,
  input  logic                                           reset,
  input  logic [`RENAME_WIDTH-1:0]                       alloc_req,
  input  rename_ops_pkg::release_t [`RENAME_WIDTH-1:0]   releases,
  input  logic                                           recover,
  input  rename_types_pkg::fl_ptr_t                      restore_head,
  output rename_types_pkg::preg_t [`RENAME_WIDTH-1:0]    alloc_preg,
  output rename_types_pkg::fl_ptr_t                      head,
  output logic                                           allocatable
);

  import rename_types_pkg::*;
  import rename_ops_pkg::*;

  preg_t   entries [`PHYS_REGS];
  fl_ptr_t tail;
  fl_ptr_t alloc_count;
  fl_ptr_t free_count;

  ////////////////////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////////////////////

  // Next registers in queue order, whether or not they get taken
  always_comb begin
    fl_ptr_t rd_ptr;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      rd_ptr        = head + fl_ptr_t'(k);
      alloc_preg[k] = entries[rd_ptr[`PREG_BITS-1:0]];
    end
  end

  always_comb begin
    alloc_count = '0;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      alloc_count = alloc_count + fl_ptr_t'(alloc_req[k]);
    end
  end

  assign free_count  = tail - head;
  assign allocatable = free_count >= fl_ptr_t'(`RENAME_WIDTH);

  ////////////////////////////////////////////////////////////////////////////
  // Pointer and storage update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    fl_ptr_t wr_ptr;
    if (reset) begin
      // Registers above the architectural ones start out free
      for (int i = 0; i < `PHYS_REGS; i++) begin
        entries[i] <= preg_t'(i + `ARCH_REGS);
      end
      head <= '0;
      tail <= fl_ptr_t'(`PHYS_REGS - `ARCH_REGS);
    end else begin
      if (recover) begin
        head <= restore_head;
      end else begin
        head <= head + alloc_count;
      end

      // Releases packed at the tail in slot order
      wr_ptr = tail;
      for (int k = 0; k < `RENAME_WIDTH; k++) begin
        if (releases[k].valid) begin
          entries[wr_ptr[`PREG_BITS-1:0]] <= releases[k].preg;
          wr_ptr = wr_ptr + 1'b1;
        end
      end
      tail <= wr_ptr;
    end
  end

endmodule

`default_nettype wire

// ==== hw/checkpoint_store.sv ====
/*
 * Storage for recovery snapshots. One entry is written per checkpoint and
 * the entry chosen by read_idx is always visible on snap_out.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module checkpoint_store (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          write,
  input  rename_types_pkg::ckpt_idx_t   write_idx,
  input  rename_ops_pkg::snapshot_t     snap_in,
  input  rename_types_pkg::ckpt_idx_t   read_idx,
  output rename_ops_pkg::snapshot_t     snap_out
);

  import rename_ops_pkg::*;

  snapshot_t snaps [`CHECKPOINTS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CHECKPOINTS; i++) begin
        snaps[i] <= '0;
      end
    end else if (write) begin
      snaps[write_idx] <= snap_in;
    end
  end

  assign snap_out = snaps[read_idx];

endmodule

`default_nettype wire

// ==== hw/map_table.sv ====
/*
 * Architectural to physical map table. Renames one group per cycle with
 * bypass between slots, builds the checkpoint snapshot at the chosen slot
 * and reloads the whole map on recovery.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module map_table (
  input  logic                                             clock,
  input  logic                                             reset,
  input  logic                                             stall,
  input  rename_ops_pkg::rename_req_t [`RENAME_WIDTH-1:0]  req,
  input  logic                                             check,
  input  rename_types_pkg::slot_idx_t                      check_slot,
  input  logic                                             recover,
  input  rename_ops_pkg::snapshot_t                        snap_out,
  input  rename_types_pkg::preg_t [`RENAME_WIDTH-1:0]      alloc_preg,
  input  rename_types_pkg::fl_ptr_t                        head,
  input  logic                                             allocatable,
  output rename_ops_pkg::rename_rsp_t [`RENAME_WIDTH-1:0]  rsp,
  output logic [`RENAME_WIDTH-1:0]                         alloc_req,
  output logic                                             ckpt_write,
  output rename_ops_pkg::snapshot_t                        snap_in
);

  import rename_types_pkg::*;
  import rename_ops_pkg::*;

  preg_t [`ARCH_REGS-1:0] map_q;
  preg_t [`ARCH_REGS-1:0] work;
  preg_t [`ARCH_REGS-1:0] snap_map;
  logic  [`SLOT_BITS:0]   taken;
  logic  [`SLOT_BITS:0]   snap_taken;
  logic                   advance;

  assign advance = !stall && allocatable;

  ////////////////////////////////////////////////////////////////////////////
  // Group rename
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    work       = map_q;
    taken      = '0;
    snap_map   = map_q;
    snap_taken = '0;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      // Sources see renames of earlier slots only
      rsp[k].prs1     = work[req[k].rs1];
      rsp[k].prs2     = work[req[k].rs2];
      rsp[k].prev_prd = work[req[k].rd];
      rsp[k].prd      = alloc_preg[taken[`SLOT_BITS-1:0]];
      if (req[k].valid) begin
        work[req[k].rd] = alloc_preg[taken[`SLOT_BITS-1:0]];
        taken           = taken + 1'b1;
      end
      if (slot_idx_t'(k) == check_slot) begin
        snap_map   = work;
        snap_taken = taken;
      end
    end
  end

  always_comb begin
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      alloc_req[k] = req[k].valid && advance;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checkpoint
  ////////////////////////////////////////////////////////////////////////////

  assign snap_in.map     = snap_map;
  assign snap_in.fl_head = head + fl_ptr_t'(snap_taken);

  // Recover wins over a checkpoint in the same cycle
  assign ckpt_write = check && advance && !recover;

  ////////////////////////////////////////////////////////////////////////////
  // Map state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // Identity mapping
      for (int i = 0; i < `ARCH_REGS; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else if (recover) begin
      map_q <= snap_out.map;
    end else if (advance) begin
      map_q <= work;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rename_unit.sv ====
/*
 * Integer rename stage. Joins the map table, the free list and the
 * checkpoint store; commit logic returns registers through releases.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_unit (
  input  logic                                             clock,
  input  logic                                             reset,
  input  rename_ops_pkg::rename_req_t [`RENAME_WIDTH-1:0]  req,
  input  logic                                             stall,
  input  logic                                             check,
  input  rename_types_pkg::ckpt_idx_t                      check_idx,
  input  rename_types_pkg::slot_idx_t                      check_slot,
  input  logic                                             recover,
  input  rename_types_pkg::ckpt_idx_t                      recover_idx,
  input  rename_ops_pkg::release_t [`RENAME_WIDTH-1:0]     releases,
  output rename_ops_pkg::rename_rsp_t [`RENAME_WIDTH-1:0]  rsp,
  output logic                                             allocatable
);

  import rename_types_pkg::*;
  import rename_ops_pkg::*;

  logic [`RENAME_WIDTH-1:0]  alloc_req;
  preg_t [`RENAME_WIDTH-1:0] alloc_preg;
  fl_ptr_t                   head;
  logic                      ckpt_write;
  snapshot_t                 snap_in;
  snapshot_t                 snap_out;

  map_table map_table_i (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .req         (req),
    .check       (check),
    .check_slot  (check_slot),
    .recover     (recover),
    .snap_out    (snap_out),
    .alloc_preg  (alloc_preg),
    .head        (head),
    .allocatable (allocatable),
    .rsp         (rsp),
    .alloc_req   (alloc_req),
    .ckpt_write  (ckpt_write),
    .snap_in     (snap_in)
  );

  free_list free_list_i (
    .clock        (clock),
    .reset        (reset),
    .alloc_req    (alloc_req),
    .releases     (releases),
    .recover      (recover),
    .restore_head (snap_out.fl_head),
    .alloc_preg   (alloc_preg),
    .head         (head),
    .allocatable  (allocatable)
  );

  checkpoint_store checkpoint_store_i (
    .clock     (clock),
    .reset     (reset),
    .write     (ckpt_write),
    .write_idx (check_idx),
    .snap_in   (snap_in),
    .read_idx  (recover_idx),
    .snap_out  (snap_out)
  );

endmodule

`default_nettype wire

// ==== testbench/rename_unit_tb.sv ====
/*
 * Directed testbench for the rename stage. A model of the map table and
 * the free queue predicts every response and is stepped once per group.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_unit_tb;

  import rename_types_pkg::*;
  import rename_ops_pkg::*;

  logic                            clock;
  logic                            reset;
  logic                            stall;
  logic                            check;
  logic                            recover;
  ckpt_idx_t                       check_idx;
  ckpt_idx_t                       recover_idx;
  slot_idx_t                       check_slot;
  rename_req_t [`RENAME_WIDTH-1:0] req;
  release_t [`RENAME_WIDTH-1:0]    releases;
  rename_rsp_t [`RENAME_WIDTH-1:0] rsp;
  logic                            allocatable;

  // Model state, plus the result of the group now on req
  preg_t       model_map [`ARCH_REGS];
  preg_t       next_map [`ARCH_REGS];
  preg_t       snap_map [`ARCH_REGS];
  preg_t       saved_map [`ARCH_REGS];
  preg_t       free_q [$];
  preg_t       saved_free [$];
  preg_t       retired [$];
  preg_t       next_prev [$];
  int          next_taken;
  int          snap_taken;
  logic [31:0] rng;

  rename_unit dut_i (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .stall       (stall),
    .check       (check),
    .check_idx   (check_idx),
    .check_slot  (check_slot),
    .recover     (recover),
    .recover_idx (recover_idx),
    .releases    (releases),
    .rsp         (rsp),
    .allocatable (allocatable)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic rename_req_t random_req();
    rename_req_t r;
    rng     = xorshift(rng);
    r.valid = 1'b1;
    r.rs1   = areg_t'(rng);
    r.rs2   = areg_t'(rng >> 8);
    r.rd    = areg_t'(rng >> 16);
    return r;
  endfunction

  task automatic expect_preg(input string name, input preg_t got, input preg_t exp);
    assert (got == exp) else begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic drive_defaults();
    stall       = 1'b0;
    check       = 1'b0;
    recover     = 1'b0;
    check_idx   = '0;
    recover_idx = '0;
    check_slot  = '0;
    req         = '0;
    releases    = '0;
  endtask

  // Predict the group on req and compare with rsp
  task automatic check_group(input rename_req_t [`RENAME_WIDTH-1:0] grp);
    next_map   = model_map;
    next_taken = 0;
    next_prev  = {};
    expect_preg("allocatable", preg_t'(allocatable), preg_t'(free_q.size() >= `RENAME_WIDTH));
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      expect_preg($sformatf("rsp[%0d].prs1", k), rsp[k].prs1, next_map[grp[k].rs1]);
      expect_preg($sformatf("rsp[%0d].prs2", k), rsp[k].prs2, next_map[grp[k].rs2]);
      expect_preg($sformatf("rsp[%0d].prev_prd", k), rsp[k].prev_prd, next_map[grp[k].rd]);
      if (grp[k].valid) begin
        expect_preg($sformatf("rsp[%0d].prd", k), rsp[k].prd, free_q[next_taken]);
        next_prev.push_back(next_map[grp[k].rd]);
        next_map[grp[k].rd] = free_q[next_taken];
        next_taken++;
      end
      // Checkpoint slot is always 0 here
      if (k == 0) begin
        snap_map   = next_map;
        snap_taken = next_taken;
      end
    end
  endtask

  task automatic run_group(input rename_req_t [`RENAME_WIDTH-1:0] grp, input logic take_ckpt);
    @(negedge clock);
    drive_defaults();
    req       = grp;
    check     = take_ckpt;
    check_idx = ckpt_idx_t'(1);
    #2;
    check_group(grp);
    if (take_ckpt) begin
      saved_map  = snap_map;
      saved_free = free_q;
      repeat (snap_taken) void'(saved_free.pop_front());
    end
    model_map = next_map;
    repeat (next_taken) void'(free_q.pop_front());
    foreach (next_prev[i]) retired.push_back(next_prev[i]);
  endtask

  // Every mapping read back through slot 0 while stalled
  task automatic check_map();
    for (int i = 0; i < `ARCH_REGS; i += 2) begin
      @(negedge clock);
      drive_defaults();
      stall      = 1'b1;
      req[0].rs1 = areg_t'(i);
      req[0].rs2 = areg_t'(i + 1);
      #2;
      expect_preg($sformatf("map[%0d]", i), rsp[0].prs1, model_map[i]);
      expect_preg($sformatf("map[%0d]", i + 1), rsp[0].prs2, model_map[i + 1]);
    end
  endtask

  task automatic release_regs(input int n);
    int exp_alloc;
    @(negedge clock);
    drive_defaults();
    exp_alloc = free_q.size() >= `RENAME_WIDTH;
    for (int k = 0; k < n; k++) begin
      releases[k].valid = 1'b1;
      releases[k].preg  = retired.pop_front();
      free_q.push_back(releases[k].preg);
    end
    #2;
    expect_preg("allocatable", preg_t'(allocatable), preg_t'(exp_alloc));
  endtask

  task automatic same_group_bypass();
    rename_req_t [`RENAME_WIDTH-1:0] grp;
    grp[0] = '{valid: 1'b1, rs1: areg_t'(1), rs2: areg_t'(2), rd: areg_t'(7)};
    grp[1] = '{valid: 1'b1, rs1: areg_t'(7), rs2: areg_t'(3), rd: areg_t'(7)};
    run_group(grp, 1'b0);
  endtask

  task automatic stall_holds();
    rename_req_t [`RENAME_WIDTH-1:0] grp;
    grp[0] = random_req();
    grp[1] = random_req();
    repeat (3) begin
      @(negedge clock);
      drive_defaults();
      req   = grp;
      stall = 1'b1;
      #2;
      check_group(grp);
    end
    check_map();
    run_group(grp, 1'b0);
  endtask

  task automatic exhaust_and_refill();
    rename_req_t [`RENAME_WIDTH-1:0] grp;
    int guard;
    guard = 0;
    @(negedge clock);
    drive_defaults();
    #2;
    while (allocatable) begin
      assert (guard < 40) else begin
        $display("free list did not run out after %0d groups", guard);
        $display("Test failed");
        $fatal(1);
      end
      grp[0] = random_req();
      grp[1] = random_req();
      run_group(grp, 1'b0);
      guard++;
      // Sample allocatable once the group has been taken
      @(negedge clock);
      drive_defaults();
      #2;
    end
    // Low until two registers are back, then the released ones come out first
    release_regs(1);
    release_regs(1);
    release_regs(0);
    run_group(grp, 1'b0);
  endtask

  task automatic checkpoint_recover();
    rename_req_t [`RENAME_WIDTH-1:0] grp;
    repeat (3) release_regs(2);
    for (int g = 0; g < 3; g++) begin
      grp[0] = random_req();
      grp[1] = random_req();
      run_group(grp, g == 0);
    end
    @(negedge clock);
    drive_defaults();
    recover     = 1'b1;
    recover_idx = ckpt_idx_t'(1);
    model_map   = saved_map;
    free_q      = saved_free;
    check_map();
    run_group(grp, 1'b0);
  endtask

  initial begin
    rng = 32'h51c00bd4;
    drive_defaults();
    reset = 1'b1;
    for (int i = 0; i < `ARCH_REGS; i++) begin
      model_map[i] = preg_t'(i);
    end
    for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
      free_q.push_back(preg_t'(i));
    end
    repeat (2) @(negedge clock);
    reset = 1'b0;

    check_map();
    same_group_bypass();
    stall_holds();
    exhaust_and_refill();
    checkpoint_recover();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rename_unit.f ====
+incdir+include
hw/rename_types_pkg.sv
hw/rename_ops_pkg.sv
hw/free_list.sv
hw/checkpoint_store.sv
hw/map_table.sv
hw/rename_unit.sv
testbench/rename_unit_tb.sv

// ==== run_rename.sh ====
#!/bin/sh
# Build the rename stage testbench with Verilator and run it.
# The run passes only if the simulation prints the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f rename_unit.f \
  --top-module rename_unit_tb -o rename_unit_sim &&
./obj_dir/rename_unit_sim | tee /dev/stderr | grep -q "^Test passed$" &&
echo "PASS" || { echo "FAIL"; exit 1; }
